// File: common/cnn_pkg.sv
package cnn_pkg;

    // Image and filter geometry
    localparam int PIX_W             = 8;
    localparam int IMG_QUADS         = 8;  // Quads per row of the 16x16 image
    localparam int BLOCKS_PER_ROW    = 7;  // 4x4 blocks at a stride of one quad
    localparam int BLOCKS_PER_FILTER = BLOCKS_PER_ROW * BLOCKS_PER_ROW;
    localparam int NUM_FILTERS       = 4;

    // Stream framing
    localparam int WORDS_PER_BLOCK   = 11;  // Header, nine windows, command
    localparam int LAST_PHASE        = WORDS_PER_BLOCK - 1;
    localparam int PARAMS_PER_FILTER = 10;  // Bias first, then the nine weights
    localparam int MAC_COUNT         = 9;

    // Address widths of the external RAMs
    localparam int IMG_ADDR_W  = 6;
    localparam int CONV_ADDR_W = 6;
    localparam int RES_ADDR_W  = 10;

    // Engine command: max-pool followed by ReLU
    localparam logic [PIX_W-1:0] CMD_POOL_RELU  = 8'hC1;
    localparam logic [PIX_W-1:0] CMD_POOL_PARAM = 8'h28;

    // Lane o holds pixel (o/2, o mod 2) of a 2x2 group
    typedef struct packed {
        logic [PIX_W-1:0] lane3;
        logic [PIX_W-1:0] lane2;
        logic [PIX_W-1:0] lane1;
        logic [PIX_W-1:0] lane0;
    } quad_t;

    typedef struct packed {
        logic [PIX_W-1:0] opcode;
        logic [PIX_W-1:0] mac_count;
        logic [PIX_W-1:0] spare1;
        logic [PIX_W-1:0] spare0;
    } cmd_t;

    // Header and command words reuse the lane bits as a command
    typedef union packed {
        quad_t win;
        cmd_t  cmd;
    } lane_word_u;

    typedef enum logic [1:0] {
        KIND_HEADER  = 2'd0,
        KIND_WINDOW  = 2'd1,
        KIND_COMMAND = 2'd2
    } word_kind_e;

    typedef struct packed {
        logic             valid;
        word_kind_e       kind;
        lane_word_u       lanes;
        logic [PIX_W-1:0] param;  // Bias, weight or command parameter
    } stream_word_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] phase;     // 0 to LAST_PHASE
        logic [3:0] quad_sel;  // One-hot quad of the block, zero after phase 3
        logic       last;      // Final word of the frame
    } seq_tag_t;

    typedef struct packed {
        logic                  en;
        logic [1:0]            bank;
        logic [RES_ADDR_W-1:0] addr;
        logic [PIX_W-1:0]      data;
    } res_wr_t;

endpackage

// File: fetch/fetch_sequencer.sv
`timescale 1ns/10ps

module fetch_sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    output logic [cnn_pkg::IMG_ADDR_W-1:0]  image_addr,
    output logic [cnn_pkg::CONV_ADDR_W-1:0] conv_addr,
    output cnn_pkg::seq_tag_t               tag,
    output logic                            busy
);
    import cnn_pkg::*;

    logic       active;   // Phases are being issued
    logic [3:0] phase;
    logic [2:0] blk_col;
    logic [2:0] blk_row;
    logic [1:0] filt;
    logic [1:0] drain;    // Cycles left until the final word clears the pipeline

    logic       last_phase;
    logic       last_col;
    logic       last_row;
    logic       last_filt;
    logic       last_word;

    logic [3:0]            param_sel;
    logic [IMG_ADDR_W-1:0] quad_row;
    logic [IMG_ADDR_W-1:0] quad_col;

    assign last_phase = (phase == 4'(LAST_PHASE));
    assign last_col   = (blk_col == 3'(BLOCKS_PER_ROW - 1));
    assign last_row   = (blk_row == 3'(BLOCKS_PER_ROW - 1));
    assign last_filt  = (filt == 2'(NUM_FILTERS - 1));
    assign last_word  = active && last_phase && last_col && last_row && last_filt;

    assign busy = active || (drain != 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            phase   <= '0;
            blk_col <= '0;
            blk_row <= '0;
            filt    <= '0;
            drain   <= '0;
        end else begin
            if (drain != 2'd0)
                drain <= drain - 2'd1;

            if (!active) begin
                if (start && !busy) begin  // Restart at filter 0, block (0, 0)
                    active  <= 1'b1;
                    phase   <= '0;
                    blk_col <= '0;
                    blk_row <= '0;
                    filt    <= '0;
                end
            end else if (last_phase) begin
                phase <= '0;
                if (last_word) begin
                    active <= 1'b0;
                    drain  <= 2'd3;  // Tag delay, word register, done cycle
                end

                // Row-major over the blocks, then the next filter
                blk_col <= last_col ? 3'd0 : blk_col + 3'd1;
                if (last_col) begin
                    blk_row <= last_row ? 3'd0 : blk_row + 3'd1;
                    if (last_row)
                        filt <= last_filt ? 2'd0 : filt + 2'd1;
                end
            end else begin
                phase <= phase + 4'd1;
            end
        end
    end

    // Quad z of block (br, bc) sits at quad row br + z/2, quad column bc + z mod 2.
    // After phase 3 the read is harmless and its data is not captured.
    assign quad_row   = IMG_ADDR_W'(blk_row) + IMG_ADDR_W'(phase[1]);
    assign quad_col   = IMG_ADDR_W'(blk_col) + IMG_ADDR_W'(phase[0]);
    assign image_addr = quad_row * IMG_ADDR_W'(IMG_QUADS) + quad_col;

    // Bias, nine weights, then the last weight address is simply held
    assign param_sel = (phase > 4'(PARAMS_PER_FILTER - 1)) ?
                       4'(PARAMS_PER_FILTER - 1) : phase;
    assign conv_addr = CONV_ADDR_W'(filt) * CONV_ADDR_W'(PARAMS_PER_FILTER)
                     + CONV_ADDR_W'(param_sel);

    always_comb begin
        tag.valid    = active;
        tag.phase    = phase;
        tag.quad_sel = 4'b0000;
        if (active && (phase < 4'd4))
            tag.quad_sel = 4'b0001 << phase[1:0];
        tag.last     = last_word;
    end

endmodule

// File: fetch/window_buffer.sv
`timescale 1ns/10ps

module window_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  cnn_pkg::seq_tag_t          tag,
    input  cnn_pkg::quad_t             image_q,
    input  logic [cnn_pkg::PIX_W-1:0]  conv_q,
    output cnn_pkg::stream_word_t      stream,
    output logic                       done
);
    import cnn_pkg::*;

    seq_tag_t         tag_q;        // Lines up with the RAM read data
    logic [PIX_W-1:0] blk [4][4];   // Block pixels as [row][col]
    logic [3:0]       win_k;        // Weight index of a window phase
    logic [1:0]       win_dr;
    logic [1:0]       win_dc;
    quad_t            window;
    stream_word_t     next_word;
    logic             last_q;

    always_ff @(posedge clk) begin
        if (reset)
            tag_q <= '0;
        else
            tag_q <= tag;
    end

    // Quad z fills rows 2*(z/2)..+1 and columns 2*(z mod 2)..+1
    always_ff @(posedge clk) begin
        for (int z = 0; z < 4; z++) begin
            if (tag_q.valid && tag_q.quad_sel[z]) begin
                blk[2*(z/2)][2*(z%2)]         <= image_q.lane0;
                blk[2*(z/2)][2*(z%2) + 1]     <= image_q.lane1;
                blk[2*(z/2) + 1][2*(z%2)]     <= image_q.lane2;
                blk[2*(z/2) + 1][2*(z%2) + 1] <= image_q.lane3;
            end
        end
    end

    // Four output positions share the weight at offset (dr, dc).
    // The quads a window needs were all written in earlier cycles.
    always_comb begin
        win_k  = tag_q.phase - 4'd1;
        win_dr = 2'(win_k / 4'd3);
        win_dc = 2'(win_k % 4'd3);
        window.lane0 = blk[win_dr][win_dc];
        window.lane1 = blk[win_dr][win_dc + 2'd1];
        window.lane2 = blk[win_dr + 2'd1][win_dc];
        window.lane3 = blk[win_dr + 2'd1][win_dc + 2'd1];
    end

    always_comb begin
        next_word       = '0;
        next_word.valid = tag_q.valid;
        next_word.param = conv_q;
        if (tag_q.phase == 4'd0) begin
            next_word.kind                = KIND_HEADER;  // Param carries the bias
            next_word.lanes.cmd.opcode    = '0;
            next_word.lanes.cmd.mac_count = PIX_W'(MAC_COUNT);
        end else if (tag_q.phase == 4'(LAST_PHASE)) begin
            next_word.kind             = KIND_COMMAND;
            next_word.lanes.cmd.opcode = CMD_POOL_RELU;
            next_word.param            = CMD_POOL_PARAM;
        end else begin
            next_word.kind      = KIND_WINDOW;
            next_word.lanes.win = window;
        end
    end

    always_ff @(posedge clk) begin
        stream.kind  <= next_word.kind;
        stream.lanes <= next_word.lanes;
        stream.param <= next_word.param;
        if (reset) begin
            stream.valid <= 1'b0;
            last_q       <= 1'b0;
            done         <= 1'b0;
        end else begin
            stream.valid <= next_word.valid;
            last_q       <= tag_q.valid && tag_q.last;  // Final command word goes out
            done         <= last_q;
        end
    end

endmodule

// File: design/result_writeback.sv
`timescale 1ns/10ps

module result_writeback (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      result_valid,
    input  logic [cnn_pkg::PIX_W-1:0] result_data,
    output cnn_pkg::res_wr_t          res_wr
);
    import cnn_pkg::*;

    // Result count; low two bits pick the bank, the rest is the address
    logic [RES_ADDR_W+1:0] res_idx;
    logic [RES_ADDR_W+1:0] cur_idx;

    assign cur_idx = start ? '0 : res_idx;  // A new frame writes from bank 0, address 0

    always_ff @(posedge clk) begin
        res_wr.bank <= cur_idx[1:0];
        res_wr.addr <= cur_idx[RES_ADDR_W+1:2];
        res_wr.data <= result_data;
        if (reset) begin
            res_wr.en <= 1'b0;
            res_idx   <= '0;
        end else begin
            res_wr.en <= result_valid;
            if (result_valid)
                res_idx <= cur_idx + 1'b1;  // All four banks, then the next address
            else
                res_idx <= cur_idx;
        end
    end

endmodule

// File: design/cnn_layer12_top.sv
`timescale 1ns/10ps

module cnn_layer12_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  cnn_pkg::quad_t                  image_q,
    input  logic [cnn_pkg::PIX_W-1:0]       conv_q,
    input  logic                            result_valid,
    input  logic [cnn_pkg::PIX_W-1:0]       result_data,
    output logic [cnn_pkg::IMG_ADDR_W-1:0]  image_addr,
    output logic [cnn_pkg::CONV_ADDR_W-1:0] conv_addr,
    output cnn_pkg::stream_word_t           stream,
    output cnn_pkg::res_wr_t                res_wr,
    output logic                            busy,
    output logic                            done
);
    import cnn_pkg::*;

    seq_tag_t tag;       // Phase tag toward the window buffer
    logic     wb_start;  // Start as accepted by the sequencer

    // A start during a frame leaves the write-back index alone
    assign wb_start = start && !busy;

    fetch_sequencer i_fetch_sequencer (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .image_addr (image_addr),
        .conv_addr  (conv_addr),
        .tag        (tag),
        .busy       (busy)
    );

    window_buffer i_window_buffer (
        .clk     (clk),
        .reset   (reset),
        .tag     (tag),
        .image_q (image_q),
        .conv_q  (conv_q),
        .stream  (stream),
        .done    (done)
    );

    result_writeback i_result_writeback (
        .clk          (clk),
        .reset        (reset),
        .start        (wb_start),
        .result_valid (result_valid),
        .result_data  (result_data),
        .res_wr       (res_wr)
    );

endmodule

// File: tb/tb_mem_rules.svh
// Contents of the modelled RAMs, included inside a module body

// Image bank b at address a
function automatic logic [cnn_pkg::PIX_W-1:0] image_cell(input int bank, input int addr);
    return 8'((4 * addr + bank + 1) % 256);
endfunction

// Parameter RAM, bias at f*10 and the nine weights after it
function automatic logic [cnn_pkg::PIX_W-1:0] param_cell(input int addr);
    return 8'((3 * addr + 5) % 256);
endfunction

// Pixel (r, c) of the 16x16 image
function automatic logic [cnn_pkg::PIX_W-1:0] pixel_at(input int r, input int c);
    int bank;
    int addr;
    bank = (r % 2) * 2 + (c % 2);
    addr = (r / 2) * cnn_pkg::IMG_QUADS + c / 2;
    return image_cell(bank, addr);
endfunction

// File: tb/cnn_layer12_props.sv
`timescale 1ns/10ps

module cnn_layer12_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      start,
    input logic                      busy,
    input logic                      done,
    input cnn_pkg::stream_word_t     stream,
    input cnn_pkg::res_wr_t          res_wr,
    input logic                      result_valid,
    input logic [cnn_pkg::PIX_W-1:0] result_data
);
    import cnn_pkg::*;
    `include "tb_mem_rules.svh"

    localparam int FRAME_WORDS = NUM_FILTERS * BLOCKS_PER_FILTER * WORDS_PER_BLOCK;

    int                    assert_errors = 0;  // Read by the testbench
    logic                  accepted;
    logic                  seen_start;
    logic [3:0]            pos;        // Word position inside the block
    logic [2:0]            col;
    logic [2:0]            row;
    logic [1:0]            filt;
    int                    frame_words;
    logic [RES_ADDR_W+1:0] res_n;
    logic [RES_ADDR_W+1:0] res_n_cur;
    logic [1:0]            exp_bank;
    logic [RES_ADDR_W-1:0] exp_addr;
    logic [PIX_W-1:0]      exp_data;
    logic [PIX_W-1:0]      exp_param;
    quad_t                 exp_win;

    function automatic quad_t expected_window(input int br, input int bc, input int k);
        quad_t q;
        int    r0;
        int    c0;
        r0 = 2 * br + k / 3;
        c0 = 2 * bc + k % 3;
        q.lane0 = pixel_at(r0, c0);
        q.lane1 = pixel_at(r0, c0 + 1);
        q.lane2 = pixel_at(r0 + 1, c0);
        q.lane3 = pixel_at(r0 + 1, c0 + 1);
        return q;
    endfunction

    assign accepted  = start && !busy;
    assign res_n_cur = accepted ? '0 : res_n;

    always_ff @(posedge clk) begin
        if (reset)
            seen_start <= 1'b0;
        else if (start)
            seen_start <= 1'b1;
    end

    // Block position of the word now on the stream
    always_ff @(posedge clk) begin
        if (reset || accepted) begin
            pos         <= '0;
            col         <= '0;
            row         <= '0;
            filt        <= '0;
            frame_words <= 0;
        end else if (stream.valid) begin
            frame_words <= frame_words + 1;
            pos <= (pos == 4'(LAST_PHASE)) ? 4'd0 : pos + 4'd1;
            if (pos == 4'(LAST_PHASE)) begin
                col <= (col == 3'(BLOCKS_PER_ROW - 1)) ? 3'd0 : col + 3'd1;
                if (col == 3'(BLOCKS_PER_ROW - 1)) begin
                    row <= (row == 3'(BLOCKS_PER_ROW - 1)) ? 3'd0 : row + 3'd1;
                    if (row == 3'(BLOCKS_PER_ROW - 1))
                        filt <= filt + 2'd1;
                end
            end
        end
    end

    // n-th result since start goes to bank n mod 4, address n/4
    always_ff @(posedge clk) begin
        exp_bank <= res_n_cur[1:0];
        exp_addr <= res_n_cur[RES_ADDR_W+1:2];
        exp_data <= result_data;
        if (reset)
            res_n <= '0;
        else
            res_n <= result_valid ? res_n_cur + 1'b1 : res_n_cur;
    end

    always_comb begin
        exp_param = param_cell(int'(filt) * PARAMS_PER_FILTER + int'(pos));
        exp_win   = '0;
        if (pos >= 4'd1 && pos <= 4'd9)
            exp_win = expected_window(int'(row), int'(col), int'(pos) - 1);
    end

    a_idle: assert property (@(posedge clk) disable iff (reset)
        !seen_start |-> !stream.valid && !res_wr.en && !busy && !done)
        else begin
            $error("Outputs active after reset before any start");
            assert_errors++;
        end

    a_header: assert property (@(posedge clk) disable iff (reset)
        stream.valid && pos == 4'd0 |-> stream.kind == KIND_HEADER
            && stream.lanes.cmd.opcode == 8'd0 && stream.lanes.cmd.mac_count == 8'(MAC_COUNT))
        else begin
            $error("Error at %0t: stream kind/opcode/macs expected %0d/%h/%0d, got %0d/%h/%0d",
                   $time, KIND_HEADER, 8'd0, MAC_COUNT, $sampled(stream.kind),
                   $sampled(stream.lanes.cmd.opcode), $sampled(stream.lanes.cmd.mac_count));
            assert_errors++;
        end

    a_param: assert property (@(posedge clk) disable iff (reset)
        stream.valid && pos < 4'(LAST_PHASE) |-> stream.param == exp_param)
        else begin
            $error("Error at %0t: stream.param expected %0h, got %0h",
                   $time, $sampled(exp_param), $sampled(stream.param));
            assert_errors++;
        end

    a_window: assert property (@(posedge clk) disable iff (reset)
        stream.valid && pos >= 4'd1 && pos <= 4'd9 |->
            stream.kind == KIND_WINDOW && stream.lanes.win == exp_win)
        else begin
            $error("Error at %0t: stream.lanes expected %h, got %h",
                   $time, $sampled(exp_win), $sampled(stream.lanes.win));
            assert_errors++;
        end

    a_command: assert property (@(posedge clk) disable iff (reset)
        stream.valid && pos == 4'(LAST_PHASE) |-> stream.kind == KIND_COMMAND
            && stream.lanes.cmd.opcode == CMD_POOL_RELU && stream.param == CMD_POOL_PARAM)
        else begin
            $error("Error at %0t: stream kind/opcode/param expected %0d/%h/%h, got %0d/%h/%h",
                   $time, KIND_COMMAND, CMD_POOL_RELU, CMD_POOL_PARAM, $sampled(stream.kind),
                   $sampled(stream.lanes.cmd.opcode), $sampled(stream.param));
            assert_errors++;
        end

    a_first_word: assert property (@(posedge clk) disable iff (reset)
        accepted |-> ##1 !stream.valid ##1 !stream.valid ##1 stream.valid)
        else begin
            $error("First stream word not 3 cycles after start");
            assert_errors++;
        end

    a_continuous: assert property (@(posedge clk) disable iff (reset)
        stream.valid && frame_words < FRAME_WORDS - 1 |=> stream.valid)
        else begin
            $error("Gap in the stream before the frame ended");
            assert_errors++;
        end

    a_frame_end: assert property (@(posedge clk) disable iff (reset)
        stream.valid && frame_words == FRAME_WORDS - 1 |=> done && !stream.valid)
        else begin
            $error("Frame did not end with done after the last word");
            assert_errors++;
        end

    // Busy covers the done cycle and falls right after it
    a_done_count: assert property (@(posedge clk) disable iff (reset)
        done |-> busy && frame_words == FRAME_WORDS ##1 !busy)
        else begin
            $error("Done at a wrong word count or busy not ending with done");
            assert_errors++;
        end

    a_busy: assert property (@(posedge clk) disable iff (reset)
        (accepted |=> busy) and (busy && !done |=> busy) and (stream.valid |-> busy))
        else begin
            $error("Busy low while a frame is running");
            assert_errors++;
        end

    a_writeback: assert property (@(posedge clk) disable iff (reset)
        result_valid |=> res_wr.en && res_wr.bank == exp_bank
            && res_wr.addr == exp_addr && res_wr.data == exp_data)
        else begin
            $error("Error at %0t: res_wr expected %0d/%0d/%h, got %0d/%0d/%h", $time,
                   $sampled(exp_bank), $sampled(exp_addr), $sampled(exp_data),
                   $sampled(res_wr.bank), $sampled(res_wr.addr), $sampled(res_wr.data));
            assert_errors++;
        end

    a_no_write: assert property (@(posedge clk) disable iff (reset)
        !result_valid |=> !res_wr.en)
        else begin
            $error("Result bank written without a result");
            assert_errors++;
        end

endmodule

bind cnn_layer12_top cnn_layer12_props i_props (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .stream       (stream),
    .res_wr       (res_wr),
    .result_valid (result_valid),
    .result_data  (result_data)
);

// File: tb/tb_cnn_layer12.sv
`timescale 1ns/10ps

module tb_cnn_layer12;
    import cnn_pkg::*;
    `include "tb_mem_rules.svh"

    localparam int FRAME_WORDS     = NUM_FILTERS * BLOCKS_PER_FILTER * WORDS_PER_BLOCK;
    localparam int WATCHDOG_CYCLES = 3 * 2 * FRAME_WORDS / 2 + 200;  // 1.5 x two frames

    logic                   clk;
    logic                   reset;
    logic                   start;
    quad_t                  image_q;
    logic [PIX_W-1:0]       conv_q;
    logic                   result_valid;
    logic [PIX_W-1:0]       result_data;
    logic [IMG_ADDR_W-1:0]  image_addr;
    logic [CONV_ADDR_W-1:0] conv_addr;
    stream_word_t           stream;
    res_wr_t                res_wr;
    logic                   busy;
    logic                   done;

    logic        results_on;
    logic [31:0] rng_state;
    int          word_count;
    int          results_sent;
    int          writes_seen;
    int          check_errors;
    int          tests_run;

    cnn_layer12_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .image_q      (image_q),
        .conv_q       (conv_q),
        .result_valid (result_valid),
        .result_data  (result_data),
        .image_addr   (image_addr),
        .conv_addr    (conv_addr),
        .stream       (stream),
        .res_wr       (res_wr),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return (state * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    function automatic int total_errors();
        return check_errors + i_dut.i_props.assert_errors;
    endfunction

    // Image banks and parameter RAM with one cycle of read latency
    always @(posedge clk) begin
        image_q.lane0 <= image_cell(0, int'(image_addr));
        image_q.lane1 <= image_cell(1, int'(image_addr));
        image_q.lane2 <= image_cell(2, int'(image_addr));
        image_q.lane3 <= image_cell(3, int'(image_addr));
        conv_q        <= param_cell(int'(conv_addr));
    end

    // Engine results at random
    always @(posedge clk) begin
        if (results_on) begin
            rng_state = lcg_next(rng_state);
            result_valid <= rng_state[17];
            result_data  <= rng_state[27:20];
        end else begin
            result_valid <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (stream.valid)
            word_count <= word_count + 1;
        if (result_valid)
            results_sent <= results_sent + 1;
        if (res_wr.en)
            writes_seen <= writes_seen + 1;
    end

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        tests_run++;
        if (errs == 0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errs);
    endtask

    task automatic run_frame(input string name, input bit extra_start);
        int errs0;
        int words0;
        errs0  = total_errors();
        words0 = word_count;
        @(posedge clk);
        start      <= 1'b1;
        results_on <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (extra_start) begin
            repeat (FRAME_WORDS / 2) @(posedge clk);
            start <= 1'b1;  // Mid-frame, must be ignored
            @(posedge clk);
            start <= 1'b0;
        end
        while (!done)
            @(posedge clk);
        check_count("stream word count", FRAME_WORDS, word_count - words0);
        finish_test(name, errs0);
    endtask

    initial begin
        int errs0;
        reset        = 1'b1;
        start        = 1'b0;
        results_on   = 1'b0;
        result_valid = 1'b0;
        result_data  = '0;
        image_q      = '0;
        conv_q       = '0;
        rng_state    = 32'd7;
        word_count   = 0;
        results_sent = 0;
        writes_seen  = 0;
        check_errors = 0;
        tests_run    = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Quiet outputs until the first start
        errs0 = total_errors();
        repeat (20) @(posedge clk);
        check_count("stream word count", 0, word_count);
        check_count("res_wr write count", 0, writes_seen);
        finish_test("idle after reset", errs0);

        run_frame("first frame", 1'b0);
        repeat (5) @(posedge clk);
        run_frame("second frame with ignored start", 1'b1);

        errs0 = total_errors();
        results_on <= 1'b0;
        repeat (4) @(posedge clk);
        check_count("res_wr write count", results_sent, writes_seen);
        finish_test("result write-back", errs0);

        $display("Summary: %0d tests, %0d count errors, %0d assertion failures",
                 tests_run, check_errors, i_dut.i_props.assert_errors);
        if (total_errors() == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+tb
common/cnn_pkg.sv
fetch/fetch_sequencer.sv
fetch/window_buffer.sv
design/result_writeback.sv
design/cnn_layer12_top.sv
tb/cnn_layer12_props.sv
tb/tb_cnn_layer12.sv
